/* src/conv_pkg.sv */
// shared widths and vector types for the integer to float converter
// the typedefs describe the default build only, modules size their own ports
// from parameters that start out at these values
package conv_pkg;

  // width of the unsigned integer word presented at the input
  localparam int unsigned DATA_WIDTH = 32;

  // number of fraction bits kept below the hidden one
  // bits further down are dropped by truncation
  localparam int unsigned MANT_WIDTH = 10;

  // an exponent must reach every bit position of the input word,
  // so it needs ceil(log2(DATA_WIDTH)) bits
  localparam int unsigned EXP_WIDTH = $clog2(DATA_WIDTH);

  // the raw integer word
  typedef logic [DATA_WIDTH-1:0] data_t;

  // a bit position or a zero count inside the integer word
  // both share the same range, so one type serves both uses
  typedef logic [EXP_WIDTH-1:0] exp_t;

  // the stored fraction without its hidden leading one
  typedef logic [MANT_WIDTH-1:0] mant_t;

endpackage

/* src/lzc.sv */
`timescale 1ns/10ps

// counts zeros from one end of a word up to the first set bit
// MODE 0 scans upward from bit 0 and gives the trailing zero count
// MODE 1 scans downward from the top bit and gives the leading zero count
// in both modes cnt_o is also the index of the first one in the scan order
// empty_o is high for an all-zero word, cnt_o is then meaningless
module lzc #(
  parameter int unsigned WIDTH     = 2,
  // 0 for trailing, 1 for leading
  parameter bit          MODE      = 1'b0,
  // follows from WIDTH, a larger value only widens the count port
  parameter int unsigned CNT_WIDTH = (WIDTH == 1) ? 1 : $clog2(WIDTH)
) (
  input  logic [WIDTH-1:0]     in_i,
  output logic [CNT_WIDTH-1:0] cnt_o,
  output logic                 empty_o
);

  // catches a zero width parameter while the design is being elaborated
  initial begin
    assert (WIDTH > 0) else $fatal(1, "lzc input width must be at least one bit");
  end

  if (WIDTH == 1) begin : gen_single_bit

    // a lone bit is always the first one when it is set
    assign cnt_o   = '0;
    assign empty_o = ~in_i[0];

  end else begin : gen_tree

    // the tree is a complete binary tree with LEVELS levels of nodes
    // the leaf level looks at bit pairs, every level above merges two children
    localparam int unsigned LEVELS    = $clog2(WIDTH);
    localparam int unsigned NUM_NODES = 2**LEVELS - 1;

    // the word in scan order, bit 0 is always the first one looked at
    logic [WIDTH-1:0]                 scan_word;
    // a node is hit when any bit below it is set
    logic [NUM_NODES-1:0]             node_hit;
    // index of the first set bit below a node
    logic [NUM_NODES-1:0][LEVELS-1:0] node_idx;

    // in leading mode the word is mirrored so that the same tree
    // can search from the low end in both modes
    for (genvar b = 0; b < WIDTH; b++) begin : gen_scan
      if (MODE) begin : gen_rev
        assign scan_word[b] = in_i[WIDTH-1-b];
      end else begin : gen_fwd
        assign scan_word[b] = in_i[b];
      end
    end

    // node k of level lvl lives at BASE+k, its children at CHILD+2k and CHILD+2k+1
    for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : gen_level
      localparam int unsigned BASE  = 2**lvl - 1;
      localparam int unsigned CHILD = 2**(lvl+1) - 1;

      for (genvar k = 0; k < 2**lvl; k++) begin : gen_node
        if (lvl == LEVELS - 1) begin : gen_leaf
          if (2*k + 1 < WIDTH) begin : gen_pair
            // the lower bit of the pair wins because it comes first in scan order
            assign node_hit[BASE+k] = scan_word[2*k] | scan_word[2*k+1];
            assign node_idx[BASE+k] = scan_word[2*k] ? LEVELS'(2*k) : LEVELS'(2*k+1);
          end else if (2*k + 1 == WIDTH) begin : gen_odd
            // odd width leaves a single bit in the last pair
            assign node_hit[BASE+k] = scan_word[2*k];
            assign node_idx[BASE+k] = LEVELS'(2*k);
          end else begin : gen_pad
            // leaves beyond the word never report a hit
            assign node_hit[BASE+k] = 1'b0;
            assign node_idx[BASE+k] = '0;
          end
        end else begin : gen_inner
          // the left child covers the lower indices, so it takes priority
          assign node_hit[BASE+k] = node_hit[CHILD+2*k] | node_hit[CHILD+2*k+1];
          assign node_idx[BASE+k] = node_hit[CHILD+2*k] ? node_idx[CHILD+2*k]
                                                        : node_idx[CHILD+2*k+1];
        end
      end
    end

    // the root sums up the whole word
    assign cnt_o   = CNT_WIDTH'(node_idx[0]);
    assign empty_o = ~node_hit[0];

  end

endmodule

/* src/norm_pack.sv */
`timescale 1ns/10ps

// turns the two zero counts of an integer word into a normalized float form
// and registers the result for one cycle
// the word is shifted left until its leading one sits at the top bit,
// the bits right below it become the fraction, the hidden one itself is dropped
// all outputs change only on a cycle with valid_i and are held otherwise
module norm_pack
  import conv_pkg::*;
#(
  parameter int unsigned DATA_WIDTH = conv_pkg::DATA_WIDTH,
  parameter int unsigned MANT_WIDTH = conv_pkg::MANT_WIDTH,
  parameter int unsigned EXP_WIDTH  = conv_pkg::EXP_WIDTH
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  input  logic [DATA_WIDTH-1:0] data_i,
  // number of zeros above the leading one
  input  logic [EXP_WIDTH-1:0]  lead_cnt_i,
  // no bit of data_i is set
  input  logic                  lead_empty_i,
  // number of zeros below the trailing one
  input  logic [EXP_WIDTH-1:0]  trail_cnt_i,
  output logic                  valid_o,
  output logic                  zero_o,
  output logic [EXP_WIDTH-1:0]  exp_o,
  output logic [MANT_WIDTH-1:0] mant_o,
  output logic                  inexact_o
);

  // position of the top bit of the word
  localparam int unsigned TOP_POS = DATA_WIDTH - 1;

  // the bits under the hidden one plus a zero tail as long as the fraction,
  // so that a leading one close to bit 0 still yields a full fraction
  localparam int unsigned EXT_WIDTH = TOP_POS + MANT_WIDTH;

  // word with its leading one moved up to the top bit
  logic [DATA_WIDTH-1:0] norm_word;
  // bits below the hidden one followed by zero padding
  logic [EXT_WIDTH-1:0]  frac_ext;
  // distance from the leading one down to the trailing one
  // one extra bit keeps the subtraction free of wraparound
  logic [EXP_WIDTH:0]    span;

  // next values of the result registers
  logic                  zero_d;
  logic [EXP_WIDTH-1:0]  exp_d;
  logic [MANT_WIDTH-1:0] mant_d;
  logic                  inexact_d;

  // barrel shift by the leading zero count
  // zeros come in from the bottom, which is the padding for short words
  assign norm_word = data_i << lead_cnt_i;

  // drop the hidden one at the top and append zeros below bit 0
  assign frac_ext = {norm_word[DATA_WIDTH-2:0], {MANT_WIDTH{1'b0}}};

  // the leading one sits at TOP_POS minus the leading count
  // and the trailing one sits at the trailing count, so their gap is the difference
  assign span = (EXP_WIDTH+1)'(TOP_POS) - {1'b0, lead_cnt_i} - {1'b0, trail_cnt_i};

  always_comb begin
    // an empty word sets the zero flag and clears everything else
    zero_d    = lead_empty_i;
    exp_d     = '0;
    mant_d    = '0;
    inexact_d = 1'b0;
    if (!lead_empty_i) begin
      // the exponent is the bit position of the leading one, without bias
      exp_d = EXP_WIDTH'(TOP_POS) - lead_cnt_i;
      // the fraction is the top MANT_WIDTH bits under the hidden one
      mant_d = frac_ext[EXT_WIDTH-1 -: MANT_WIDTH];
      // a gap wider than the fraction means the trailing one fell off the end
      inexact_d = (32'(span) > MANT_WIDTH);
    end
  end

  // the valid strobe follows valid_i by one cycle and never stalls
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // result registers load only with a new word and otherwise keep the last result
  // they read zero straight after reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      zero_o    <= 1'b0;
      exp_o     <= '0;
      mant_o    <= '0;
      inexact_o <= 1'b0;
    end else if (valid_i) begin
      zero_o    <= zero_d;
      exp_o     <= exp_d;
      mant_o    <= mant_d;
      inexact_o <= inexact_d;
    end
  end

endmodule

/* src/uint_to_float.sv */
`timescale 1ns/10ps

// unsigned integer to compact float converter with one cycle of latency
// two zero counters look at the same word from both ends in the same cycle,
// the combiner turns both counts into exponent, fraction and flags
// a word may enter every cycle and its result leaves with valid_o one cycle later
module uint_to_float
  import conv_pkg::*;
#(
  parameter int unsigned DATA_WIDTH = conv_pkg::DATA_WIDTH,
  parameter int unsigned MANT_WIDTH = conv_pkg::MANT_WIDTH,
  parameter int unsigned EXP_WIDTH  = conv_pkg::EXP_WIDTH
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // one-cycle strobe, data_i holds a word to convert
  input  logic  valid_i,
  input  data_t data_i,
  // result strobe, the fields below are valid only while it is high
  output logic  valid_o,
  output logic  zero_o,
  output exp_t  exp_o,
  output mant_t mant_o,
  output logic  inexact_o
);

  // zeros above the leading one of data_i
  logic [EXP_WIDTH-1:0] lead_cnt;
  // data_i has no set bit
  logic                 lead_empty;
  // zeros below the trailing one of data_i
  logic [EXP_WIDTH-1:0] trail_cnt;

  // leading zero counter, finds the most significant one
  lzc #(
    .WIDTH     (DATA_WIDTH),
    .MODE      (1'b1),
    .CNT_WIDTH (EXP_WIDTH)
  ) lzc_lead (
    .in_i    (data_i),
    .cnt_o   (lead_cnt),
    .empty_o (lead_empty)
  );

  // trailing zero counter, finds the least significant one
  // its empty flag would repeat lead_empty, so it stays open
  lzc #(
    .WIDTH     (DATA_WIDTH),
    .MODE      (1'b0),
    .CNT_WIDTH (EXP_WIDTH)
  ) lzc_trail (
    .in_i    (data_i),
    .cnt_o   (trail_cnt),
    .empty_o ()
  );

  // normalizes, packs and registers the result
  norm_pack #(
    .DATA_WIDTH (DATA_WIDTH),
    .MANT_WIDTH (MANT_WIDTH),
    .EXP_WIDTH  (EXP_WIDTH)
  ) u_norm_pack (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .valid_i      (valid_i),
    .data_i       (data_i),
    .lead_cnt_i   (lead_cnt),
    .lead_empty_i (lead_empty),
    .trail_cnt_i  (trail_cnt),
    .valid_o      (valid_o),
    .zero_o       (zero_o),
    .exp_o        (exp_o),
    .mant_o       (mant_o),
    .inexact_o    (inexact_o)
  );

endmodule

/* bench/tb_uint_to_float.sv */
`timescale 1ns/10ps

// directed testbench for the integer to float converter
// inputs change on the falling edge and outputs are read on the falling edge,
// half a cycle after the rising edge that updated them
module tb_uint_to_float
  import conv_pkg::*;
();

  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned STREAM_WORDS = 200;
  // a single word must come back after exactly one cycle, this only bounds the wait
  localparam int unsigned MAX_LATENCY  = 8;
  // reset, zero test, one word per bit, two words per boundary shift, extremes,
  // and a stream that can take up to two cycles per word because of gaps
  localparam int unsigned TEST_CYCLES  = 2 + 2 + DATA_WIDTH + 2*DATA_WIDTH + 16
                                         + 2*STREAM_WORDS + 1;
  localparam int unsigned MARGIN_CYCLES = 50;

  logic  clk;
  logic  rst_n;
  logic  in_valid;
  data_t in_data;
  logic  out_valid;
  logic  out_zero;
  exp_t  out_exp;
  mant_t out_mant;
  logic  out_inexact;

  uint_to_float dut (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .valid_i   (in_valid),
    .data_i    (in_data),
    .valid_o   (out_valid),
    .zero_o    (out_zero),
    .exp_o     (out_exp),
    .mant_o    (out_mant),
    .inexact_o (out_inexact)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // prints the reason, then the verdict, and stops the whole run
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic report_mismatch(input string field, input data_t word,
                                 input logic [31:0] got, input logic [31:0] want);
    abort_run($sformatf("MISMATCH at %0t: %s for input 0x%08h reads 0x%0h, expected 0x%0h",
                        $time, field, word, got, want));
  endtask

  task automatic expect_field(input string field, input data_t word,
                              input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else report_mismatch(field, word, got, want);
  endtask

  // reference conversion, a plain bit walk over the word
  task automatic model_convert(input data_t word, output logic zero, output exp_t expo,
                               output mant_t mant, output logic inexact);
    int    lead_pos;
    int    trail_pos;
    int    src;
    data_t tmp;
    lead_pos  = -1;
    trail_pos = -1;
    zero      = 1'b0;
    expo      = '0;
    mant      = '0;
    inexact   = 1'b0;
    for (int i = 0; i < int'(DATA_WIDTH); i++) begin
      tmp = word >> i;
      if (tmp[0]) begin
        lead_pos = i;
        if (trail_pos < 0) begin
          trail_pos = i;
        end
      end
    end
    if (lead_pos < 0) begin
      zero = 1'b1;
    end else begin
      expo = exp_t'(lead_pos);
      // fraction bits are taken one by one from just below the leading one,
      // positions under bit 0 contribute zeros
      for (int j = 0; j < int'(MANT_WIDTH); j++) begin
        src = lead_pos - 1 - j;
        tmp = (src >= 0) ? (word >> src) : '0;
        mant = {mant[MANT_WIDTH-2:0], tmp[0]};
      end
      inexact = ((lead_pos - trail_pos) > int'(MANT_WIDTH));
    end
  endtask

  // compares every result field with the model of the given word
  task automatic check_result(input data_t word);
    logic  want_zero;
    exp_t  want_exp;
    mant_t want_mant;
    logic  want_inexact;
    model_convert(word, want_zero, want_exp, want_mant, want_inexact);
    expect_field("zero_o", word, 32'(out_zero), 32'(want_zero));
    expect_field("exp_o", word, 32'(out_exp), 32'(want_exp));
    expect_field("mant_o", word, 32'(out_mant), 32'(want_mant));
    expect_field("inexact_o", word, 32'(out_inexact), 32'(want_inexact));
  endtask

  // starts and ends on a falling edge, the result is checked before returning
  task automatic convert_word(input data_t word);
    int unsigned latency;
    in_data  = word;
    in_valid = 1'b1;
    @(negedge clk);
    in_valid = 1'b0;
    in_data  = '0;
    latency  = 1;
    while (!out_valid) begin
      if (latency >= MAX_LATENCY) begin
        abort_run($sformatf("timeout: valid_o never came for input 0x%08h", word));
      end
      @(negedge clk);
      latency++;
    end
    assert (latency == 1) else begin
      abort_run($sformatf("result for input 0x%08h arrived after %0d cycles instead of one",
                          word, latency));
    end
    check_result(word);
  endtask

  task automatic test_reset_and_zero();
    // nothing has been converted yet, so the registers still hold their reset value
    expect_field("valid_o after reset", '0, 32'(out_valid), 32'd0);
    expect_field("zero_o after reset", '0, 32'(out_zero), 32'd0);
    expect_field("exp_o after reset", '0, 32'(out_exp), 32'd0);
    expect_field("mant_o after reset", '0, 32'(out_mant), 32'd0);
    expect_field("inexact_o after reset", '0, 32'(out_inexact), 32'd0);
    convert_word('0);
    expect_field("zero_o", '0, 32'(out_zero), 32'd1);
  endtask

  task automatic test_single_bits();
    data_t word;
    for (int unsigned pos = 0; pos < DATA_WIDTH; pos++) begin
      word = data_t'(1) << pos;
      convert_word(word);
      // a lone one is its own hidden bit and leaves an empty fraction
      expect_field("exp_o", word, 32'(out_exp), pos);
      expect_field("mant_o", word, 32'(out_mant), 32'd0);
      expect_field("inexact_o", word, 32'(out_inexact), 32'd0);
    end
  endtask

  task automatic test_exact_boundary();
    data_t exact_word;
    data_t lossy_word;
    for (int unsigned low = 0; low + MANT_WIDTH + 1 < DATA_WIDTH; low++) begin
      // top and bottom bits mark the span, random bits fill the inside
      exact_word = ((data_t'(1) << MANT_WIDTH) | data_t'(1)
                    | (data_t'($urandom) & ((data_t'(1) << MANT_WIDTH) - data_t'(2)))) << low;
      convert_word(exact_word);
      expect_field("inexact_o", exact_word, 32'(out_inexact), 32'd0);
      expect_field("mant_o", exact_word, 32'(out_mant), 32'(mant_t'(exact_word >> low)));
      // one more position and the trailing one no longer fits in the fraction
      lossy_word = ((data_t'(1) << (MANT_WIDTH + 1)) | data_t'(1)
                    | (data_t'($urandom) & ((data_t'(1) << (MANT_WIDTH + 1)) - data_t'(2))))
                   << low;
      convert_word(lossy_word);
      expect_field("inexact_o", lossy_word, 32'(out_inexact), 32'd1);
      expect_field("mant_o", lossy_word, 32'(out_mant),
                   32'(mant_t'(lossy_word >> (low + 1))));
    end
  endtask

  task automatic test_extremes();
    convert_word('1);
    expect_field("exp_o", '1, 32'(out_exp), 32'(DATA_WIDTH - 1));
    convert_word(data_t'(1) << (DATA_WIDTH - 1));
    expect_field("exp_o", data_t'(1) << (DATA_WIDTH - 1), 32'(out_exp), 32'(DATA_WIDTH - 1));
    // leading one below MANT_WIDTH, the low end of the fraction is padded with zeros
    convert_word(data_t'(1));
    convert_word(data_t'(3));
    convert_word(data_t'(5));
    convert_word(data_t'(10'h2a5));
    convert_word(data_t'(10'h3ff));
  endtask

  task automatic test_stream();
    data_t       word;
    logic        gap;
    logic        last_gap;
    int unsigned sent;
    word     = '0;
    sent     = 0;
    // the stream opens with a word, not with a gap
    last_gap = 1'b1;
    while (sent < STREAM_WORDS) begin
      // an idle cycle now and then, never two in a row
      gap = !last_gap && ($urandom_range(4) == 0);
      if (gap) begin
        in_valid = 1'b0;
        in_data  = data_t'($urandom);
      end else begin
        // a random shift spreads the leading one over all positions
        word     = data_t'($urandom) >> $urandom_range(DATA_WIDTH - 1);
        in_valid = 1'b1;
        in_data  = word;
        sent++;
      end
      last_gap = gap;
      @(negedge clk);
      // the strobe must mirror the input strobe of one cycle earlier
      expect_field("valid_o", word, 32'(out_valid), 32'(!gap));
      // after a gap the fields still hold the result of the last word
      check_result(word);
    end
    in_valid = 1'b0;
    in_data  = '0;
  endtask

  initial begin
    #(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
    abort_run("watchdog expired, valid_o never came for the last word");
  end

  initial begin
    void'($urandom(32'hb055));
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_data     = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    test_reset_and_zero();
    test_single_bits();
    test_exact_boundary();
    test_extremes();
    test_stream();
    $display("All checks passed");
    $finish;
  end

endmodule

/* compile.f */
src/conv_pkg.sv
src/lzc.sv
src/norm_pack.sv
src/uint_to_float.sv
bench/tb_uint_to_float.sv

/* Makefile */
# Verilator build and run for the integer to float converter

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       ?= tb_uint_to_float
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All checks passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator exit status is lost in the pipe, the log search decides
run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
